/* src/avalon_bus_pkg.sv */
`default_nettype none

package avalon_bus_pkg;

    localparam int BE_WIDTH    = 4;
    localparam int RAM_WORDS   = 256;
    localparam int WORD_IDX_W  = $clog2(RAM_WORDS);
    localparam int LOAD_ADDR_W = 8;  // the loader takes a byte address.

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;  // words sit on byte addresses that are multiples of 4.

endpackage

`default_nettype wire

/* src/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    // primary opcode field, bits 31:26 of the instruction.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,  // the function field selects the r-type operation.
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field of SPECIAL instructions, bits 5:0.
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_MFHI = 6'h10,
        FN_MTHI = 6'h11,
        FN_MFLO = 6'h12,
        FN_MTLO = 6'h13,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS  // forwards operand a unchanged.
    } alu_op_e;

    localparam logic [4:0]  REG_V0       = 5'd2;
    localparam logic [31:0] RESET_VECTOR = 32'h0000_0004;
    localparam logic [31:0] HALT_ADDR    = 32'h0000_0000;  // a jump here stops the CPU.

endpackage

`default_nettype wire

/* src/avalon_mm_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface avalon_mm_if;

    avalon_bus_pkg::addr_t address;
    logic read;
    logic write;
    avalon_bus_pkg::word_t writedata;
    logic [avalon_bus_pkg::BE_WIDTH-1:0] byteenable;
    logic waitrequest;  // high while the slave is not ready to finish.
    avalon_bus_pkg::word_t readdata;

    modport master (
        output address, read, write, writedata, byteenable,
        input  waitrequest, readdata
    );

    modport slave (
        input  address, read, write, writedata, byteenable,
        output waitrequest, readdata
    );

endinterface

`default_nettype wire

/* src/mips_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [4:0]            rs_addr,
    input  logic [4:0]            rt_addr,
    input  logic [4:0]            rd_addr,
    input  logic                  rd_we,
    input  avalon_bus_pkg::word_t rd_data,
    output avalon_bus_pkg::word_t rs_data,
    output avalon_bus_pkg::word_t rt_data,
    input  logic                  hi_we,
    input  logic                  lo_we,
    input  avalon_bus_pkg::word_t hilo_data,
    output avalon_bus_pkg::word_t hi,
    output avalon_bus_pkg::word_t lo,
    output avalon_bus_pkg::word_t v0
);

    avalon_bus_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            hi <= '0;
            lo <= '0;
        end else begin
            if (rd_we && rd_addr != 5'd0) begin  // register 0 is hardwired to zero.
                regs[rd_addr] <= rd_data;
            end
            if (hi_we) begin
                hi <= hilo_data;
            end
            if (lo_we) begin
                lo <= hilo_data;
            end
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0      = regs[mips_isa_pkg::REG_V0];

    // whatever the program writes, register 0 must still read zero on both ports.
    a_zero_reg: assert property (@(posedge clk) disable iff (!rst_n)
        (rs_addr != 5'd0 || rs_data == '0) && (rt_addr != 5'd0 || rt_data == '0));

endmodule

`default_nettype wire

/* src/mips_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
    input  mips_isa_pkg::alu_op_e op,
    input  avalon_bus_pkg::word_t a,
    input  avalon_bus_pkg::word_t b,
    output avalon_bus_pkg::word_t y
);

    // all arithmetic wraps at 32 bits and there is no overflow trap.
    always_comb begin
        case (op)
            mips_isa_pkg::ALU_ADD: begin
                y = a + b;  // ADDU, ADDIU and load or store addresses.
            end
            mips_isa_pkg::ALU_SUB: begin
                y = a - b;
            end
            mips_isa_pkg::ALU_AND: begin
                y = a & b;
            end
            mips_isa_pkg::ALU_OR: begin
                y = a | b;
            end
            mips_isa_pkg::ALU_PASS: begin
                // moves to and from HI and LO travel through here.
                y = a;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/mips_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu (
    input  logic                  clk,
    input  logic                  rst_n,
    avalon_mm_if.master           bus,
    output logic                  active,
    output avalon_bus_pkg::word_t register_v0
);

    typedef enum logic [2:0] {FETCH, EXECUTE, MEMORY, WRITEBACK, HALT} state_e;

    state_e                  state;
    avalon_bus_pkg::addr_t   pc;
    avalon_bus_pkg::word_t   ir;
    avalon_bus_pkg::word_t   alu_q;  // result held from EXECUTE.
    avalon_bus_pkg::word_t   mem_q;  // load data held from MEMORY.
    mips_isa_pkg::opcode_e   opcode;
    mips_isa_pkg::funct_e    funct;
    mips_isa_pkg::alu_op_e   alu_op;
    avalon_bus_pkg::word_t   imm_ext, alu_a, alu_b, alu_y;
    avalon_bus_pkg::word_t   rs_data, rt_data, hi, lo, v0;
    logic [4:0]              dst;
    logic                    reg_we, hi_set, lo_set, is_jr, is_lw, is_sw;

    assign opcode  = mips_isa_pkg::opcode_e'(ir[31:26]);
    assign funct   = mips_isa_pkg::funct_e'(ir[5:0]);
    assign imm_ext = {{16{ir[15]}}, ir[15:0]};  // ADDIU sign-extends too.

    always_comb begin
        alu_op = mips_isa_pkg::ALU_PASS;
        alu_a  = rs_data;
        alu_b  = imm_ext;
        dst    = ir[20:16];  // i-type instructions write rt and SPECIAL switches to rd below.
        reg_we = 1'b0;
        hi_set = 1'b0;
        lo_set = 1'b0;
        is_jr  = 1'b0;
        is_lw  = 1'b0;
        is_sw  = 1'b0;
        case (opcode)
            mips_isa_pkg::OP_ADDIU: begin
                alu_op = mips_isa_pkg::ALU_ADD;
                reg_we = 1'b1;
            end
            mips_isa_pkg::OP_LW: begin
                alu_op = mips_isa_pkg::ALU_ADD;
                reg_we = 1'b1;
                is_lw  = 1'b1;
            end
            mips_isa_pkg::OP_SW: begin
                alu_op = mips_isa_pkg::ALU_ADD;
                is_sw  = 1'b1;
            end
            mips_isa_pkg::OP_SPECIAL: begin
                alu_b  = rt_data;
                dst    = ir[15:11];
                reg_we = 1'b1;  // moves to HI or LO and JR write no register.
                case (funct)
                    mips_isa_pkg::FN_ADDU: alu_op = mips_isa_pkg::ALU_ADD;
                    mips_isa_pkg::FN_SUBU: alu_op = mips_isa_pkg::ALU_SUB;
                    mips_isa_pkg::FN_AND:  alu_op = mips_isa_pkg::ALU_AND;
                    mips_isa_pkg::FN_OR:   alu_op = mips_isa_pkg::ALU_OR;
                    mips_isa_pkg::FN_MFHI: alu_a  = hi;
                    mips_isa_pkg::FN_MFLO: alu_a  = lo;
                    mips_isa_pkg::FN_MTHI: begin
                        hi_set = 1'b1;
                        reg_we = 1'b0;
                    end
                    mips_isa_pkg::FN_MTLO: begin
                        lo_set = 1'b1;
                        reg_we = 1'b0;
                    end
                    mips_isa_pkg::FN_JR: begin
                        is_jr  = 1'b1;
                        reg_we = 1'b0;
                    end
                    default: reg_we = 1'b0;
                endcase
            end
            default: ;  // unknown opcodes retire without effect.
        endcase
    end

    mips_regfile regfile0 (
        .clk(clk), .rst_n(rst_n),
        .rs_addr(ir[25:21]), .rt_addr(ir[20:16]), .rd_addr(dst),
        .rd_we(state == WRITEBACK && reg_we), .rd_data(is_lw ? mem_q : alu_q),
        .rs_data(rs_data), .rt_data(rt_data),
        .hi_we(state == WRITEBACK && hi_set), .lo_we(state == WRITEBACK && lo_set),
        .hilo_data(alu_q), .hi(hi), .lo(lo), .v0(v0)
    );

    mips_alu alu0 (.op(alu_op), .a(alu_a), .b(alu_b), .y(alu_y));

    assign bus.byteenable = '1;  // whole words only.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= FETCH;
            pc          <= mips_isa_pkg::RESET_VECTOR;
            bus.read    <= 1'b0;
            bus.write   <= 1'b0;
            active      <= 1'b0;
            register_v0 <= '0;
        end else begin
            register_v0 <= v0;  // one cycle behind the register file.
            case (state)
                FETCH: begin
                    active <= 1'b1;
                    if (bus.read && !bus.waitrequest) begin
                        ir       <= bus.readdata;
                        bus.read <= 1'b0;
                        state    <= EXECUTE;
                    end else begin
                        bus.read    <= 1'b1;  // only the very first fetch starts here.
                        bus.address <= pc;
                    end
                end
                EXECUTE: begin
                    alu_q <= alu_y;
                    bus.address <= alu_y;
                    bus.writedata <= rt_data;
                    bus.read  <= is_lw;
                    bus.write <= is_sw;
                    state <= (is_lw || is_sw) ? MEMORY : WRITEBACK;
                end
                MEMORY: begin
                    if (!bus.waitrequest) begin
                        mem_q     <= bus.readdata;
                        bus.read  <= 1'b0;
                        bus.write <= 1'b0;
                        state     <= WRITEBACK;
                    end
                end
                WRITEBACK: begin
                    if (is_jr && rs_data == mips_isa_pkg::HALT_ADDR) begin
                        active <= 1'b0;
                        state  <= HALT;
                    end else begin
                        // the next fetch goes out straight away to keep FETCH at 2 cycles.
                        pc          <= is_jr ? rs_data : pc + 32'd4;
                        bus.address <= is_jr ? rs_data : pc + 32'd4;
                        bus.read    <= 1'b1;
                        state       <= FETCH;
                    end
                end
                default: ;  // HALT holds until the next reset.
            endcase
        end
    end

    a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus.read && bus.write));

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bus.read || bus.write) && bus.waitrequest |=> $stable(bus.address));

endmodule

`default_nettype wire

/* src/avalon_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module avalon_ram (
    input logic                                  clk,
    input logic                                  rst_n,
    avalon_mm_if.slave                           bus,
    input logic                                  load_en,
    input logic [avalon_bus_pkg::LOAD_ADDR_W-1:0] load_addr,
    input avalon_bus_pkg::word_t                 load_data
);

    avalon_bus_pkg::word_t mem [avalon_bus_pkg::RAM_WORDS];

    logic                                   ack;  // second cycle of a request.
    logic                                   req;
    logic [avalon_bus_pkg::WORD_IDX_W-1:0]  bus_idx;
    logic [avalon_bus_pkg::WORD_IDX_W-1:0]  load_idx;

    assign req      = bus.read || bus.write;
    assign bus_idx  = bus.address[avalon_bus_pkg::WORD_IDX_W+1:2];
    assign load_idx = avalon_bus_pkg::WORD_IDX_W'(load_addr[avalon_bus_pkg::LOAD_ADDR_W-1:2]);

    // every request waits exactly one cycle.
    assign bus.waitrequest = req && !ack;
    assign bus.readdata    = mem[bus_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= req && !ack;
        end
    end

    // the loader runs while the CPU is held in reset.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (bus.write && !bus.waitrequest) begin
            for (int b = 0; b < avalon_bus_pkg::BE_WIDTH; b++) begin
                if (bus.byteenable[b]) begin
                    mem[bus_idx][8*b +: 8] <= bus.writedata[8*b +: 8];
                end
            end
        end
    end

    // loading and CPU traffic must not overlap.
    a_no_load_during_req: assert property (@(posedge clk) disable iff (!rst_n)
        load_en |-> !req);

endmodule

`default_nettype wire

/* src/mips_soc.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_soc (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  load_en,
    input  logic [avalon_bus_pkg::LOAD_ADDR_W-1:0] load_addr,
    input  avalon_bus_pkg::word_t                 load_data,
    output logic                                  active,
    output avalon_bus_pkg::word_t                 register_v0
);

    avalon_mm_if bus0 ();

    // CPU is the only master on the bus.
    mips_cpu cpu0 (
        .clk(clk),
        .rst_n(rst_n),
        .bus(bus0.master),
        .active(active),
        .register_v0(register_v0)
    );

    avalon_ram ram0 (
        .clk(clk),
        .rst_n(rst_n),
        .bus(bus0.slave),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data)  // program words come in here before the run.
    );

endmodule

`default_nettype wire

/* verification/mips_soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_soc_tb;

    localparam int REC_WORDS      = 384;  // room for 128 records of three words each.
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = 1000;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   load_en;
    logic [avalon_bus_pkg::LOAD_ADDR_W-1:0] load_addr;
    avalon_bus_pkg::word_t                  load_data;
    logic                                   active;
    avalon_bus_pkg::word_t                  register_v0;

    avalon_bus_pkg::word_t recs [REC_WORDS];
    int error_count;
    int timeout_count;
    int test_count;

    mips_soc dut0 (
        .clk(clk),
        .rst_n(rst_n),
        .load_en(load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .active(active),
        .register_v0(register_v0)
    );

    always #10 clk = ~clk;  // 20 ns period.

    task automatic check_word(input string name, input avalon_bus_pkg::word_t got,
                              input avalon_bus_pkg::word_t expected);
        if (got !== expected) begin
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, expected);
            error_count++;
        end
    endtask

    // the CPU stays in reset from here until the program is fully loaded.
    task automatic hold_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
    endtask

    task automatic load_word(input logic [avalon_bus_pkg::LOAD_ADDR_W-1:0] addr,
                             input avalon_bus_pkg::word_t data);
        @(posedge clk);
        load_en   <= 1'b1;  // the RAM takes the word on the next edge.
        load_addr <= addr;
        load_data <= data;
    endtask

    // releases reset, checks how active starts and waits for the halt.
    task automatic run_program(input avalon_bus_pkg::word_t expected);
        int cycles;
        @(posedge clk);
        load_en <= 1'b0;
        @(negedge clk);
        check_bit("active", active, 1'b0);
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("active", active, 1'b0);  // first cycle out of reset.
        @(negedge clk);
        check_bit("active", active, 1'b1);
        cycles = 0;
        while (active === 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (active !== 1'b0) begin
            $display("test %0d did not halt within %0d cycles", test_count, TIMEOUT_CYCLES);
            timeout_count++;
        end else begin
            check_word("register_v0", register_v0, expected);
        end
    endtask

    initial begin
        int idx;
        bit stop;
        avalon_bus_pkg::word_t expected;
        clk           = 1'b0;
        rst_n         = 1'b0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        error_count   = 0;
        timeout_count = 0;
        test_count    = 0;
        expected      = '0;
        idx           = 0;
        stop          = 1'b0;
        void'($urandom(17));
        for (int i = 0; i < REC_WORDS; i++) begin
            recs[i] = '0;  // a zero kind marks the end of the records.
        end
        $readmemh("verification/mips_soc_testdata.txt", recs);
        hold_reset();
        while (!stop && idx <= REC_WORDS - 3 && recs[idx] != 32'd0) begin
            case (recs[idx])
                32'd1: begin
                    load_word(recs[idx + 1][avalon_bus_pkg::LOAD_ADDR_W-1:0], recs[idx + 2]);
                end
                32'd2: begin
                    expected = recs[idx + 2];
                end
                32'd3: begin
                    test_count++;
                    run_program(expected);
                    stop = (timeout_count != 0);  // a hung CPU leaves the rest untested.
                    repeat ($urandom_range(3, 0)) @(posedge clk);
                    hold_reset();
                end
                default: begin
                    $display("unknown record kind %0h at word %0d of the data file",
                             recs[idx], idx);
                    error_count++;
                    stop = 1'b1;
                end
            endcase
            idx += 3;
        end
        if (test_count == 0) begin
            $display("no test was found in the data file");
            error_count++;
        end
        $display("tests %0d, errors %0d, timeouts %0d", test_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/mips_soc_testdata.txt */
// each record is three hex fields: kind, byte address, word.
// kind 1 loads a program word, 2 sets the expected register 2 value, 3 runs the test, 0 ends.
1 04 2402ffff  1 08 00400013  1 0c 24020000  // ADDIU -1, MTLO, ADDIU 0, MFLO
1 10 00001012  1 14 00000008  2 00 ffffffff  3 00 00000000
1 04 24028001  1 08 00400011  1 0c 24020000  // the same through MTHI and MFHI
1 10 00001010  1 14 00000008  2 00 ffff8001  3 00 00000000
1 04 24087fff  1 08 2409fff0  1 0c 01095021  // ADDIU twice, ADDU
1 10 00085823  1 14 01696024  1 18 018a1025  // SUBU, AND, OR
1 1c 00000008  2 00 ffffffef  3 00 00000000
1 04 24040100  1 08 2405a5a5  1 0c ac850008  // SW to 0x108
1 10 24050000  1 14 8c820008  1 18 00000008  // clear the source, LW into register 2
2 00 ffffa5a5  3 00 00000000
1 04 24000055  1 08 24020010  1 0c 00420021  // writes to register 0
1 10 00401021  1 14 00000008  2 00 00000010  3 00 00000000
1 04 24030020  1 08 00600008  1 0c 24020099  // JR to 0x20 skips the word at 0x0c
1 20 24020007  1 24 00c00008  2 00 00000007  3 00 00000000
0 00 00000000

/* compile.f */
src/avalon_bus_pkg.sv
src/mips_isa_pkg.sv
src/avalon_mm_if.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_cpu.sv
src/avalon_ram.sv
src/mips_soc.sv
verification/mips_soc_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
TOP       ?= mips_soc_tb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
